// ==== dbg_pkg.sv ====
// Shared widths, FIFO depths, host command struct and CRC-32 constants for the debug CPU unit

package dbg_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////////////

  // SPR bus data and address width
  localparam int word_w = 32;

  // Burst count field, holds length minus one (1 to 16 words)
  localparam int burst_w = 4;

  typedef logic [word_w-1:0]  word_t;
  typedef logic [burst_w-1:0] len_t;

  // One host command, 37 bits
  typedef struct packed {
    logic  write;
    word_t addr;
    len_t  len_m1;
  } dbg_cmd_t;

  ////////////////////////////////////////////////////////////////////////////
  // Depths
  ////////////////////////////////////////////////////////////////////////////

  localparam int cmd_fifo_depth   = 2;
  localparam int rdata_fifo_depth = 8;

  // Fill-count width of the read FIFO, must hold 0 to depth
  localparam int rdata_cnt_w = $clog2(rdata_fifo_depth + 1);

  ////////////////////////////////////////////////////////////////////////////
  // CRC-32
  ////////////////////////////////////////////////////////////////////////////

  // Rule used by RTL and testbench model alike
  // Start from crc_init at each burst
  // Fold every data word MSB first, one bit per step, 32 steps
  //   feedback = crc[31] ^ data bit, shift left, xor crc_poly when feedback set
  // No final inversion, register value is the result
  localparam word_t crc_poly = 32'h04C11DB7;
  localparam word_t crc_init = 32'hFFFFFFFF;

endpackage

// ==== dbg_fifo.sv ====
// Synchronous circular-buffer FIFO with a type-parameter payload, head output and fill count
`timescale 1ns/1ps

module dbg_fifo #(
  parameter type payload_t = logic [31:0],
  parameter int  depth     = 2
) (
  input  logic                       tck_i,
  input  logic                       rst_i,
  input  logic                       push_i,
  input  payload_t                   data_i,
  input  logic                       pop_i,
  output payload_t                   data_o,
  output logic                       full_o,
  output logic                       empty_o,
  output logic [$clog2(depth+1)-1:0] count_o
);

  // Storage, depth of 2 or more
  payload_t                   mem_q [depth];
  logic [$clog2(depth)-1:0]   wr_ptr_q;
  logic [$clog2(depth)-1:0]   rd_ptr_q;
  logic [$clog2(depth+1)-1:0] count_q;

  // Qualified requests, push when full and pop when empty are dropped
  logic do_push;
  logic do_pop;

  assign full_o  = (int'(count_q) == depth);
  assign empty_o = (count_q == '0);
  assign count_o = count_q;

  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  // Head entry is always visible
  assign data_o = mem_q[rd_ptr_q];

  always_ff @(posedge tck_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      // Pointers wrap at depth, which need not be a power of two
      if (do_push) begin
        if (int'(wr_ptr_q) == depth - 1) begin
          wr_ptr_q <= '0;
        end else begin
          wr_ptr_q <= wr_ptr_q + 1'b1;
        end
      end
      if (do_pop) begin
        if (int'(rd_ptr_q) == depth - 1) begin
          rd_ptr_q <= '0;
        end else begin
          rd_ptr_q <= rd_ptr_q + 1'b1;
        end
      end
      // Simultaneous push and pop leave the count alone
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

// ==== dbg_cpu_bridge.sv ====
// Single-access bridge from the TCK domain to the OR1K SPR bus, toggle synchronizers and SPR FSM
`timescale 1ns/1ps

module dbg_cpu_bridge (
  // TCK side
  input  logic           tck_i,
  input  logic           rst_i,
  input  logic           strobe_i,
  input  logic           rd_wrn_i,
  input  dbg_pkg::word_t addr_i,
  input  dbg_pkg::word_t data_i,
  output dbg_pkg::word_t data_o,
  output logic           rdy_o,

  // SPR bus side
  input  logic           cpu_clk_i,
  output dbg_pkg::word_t cpu_addr_o,
  input  dbg_pkg::word_t cpu_data_i,
  output dbg_pkg::word_t cpu_data_o,
  output logic           cpu_stb_o,
  output logic           cpu_we_o,
  input  logic           cpu_ack_i
);

  typedef enum logic {
    st_idle,
    st_xfer
  } spr_state_t;

  // Access latched in the TCK domain, stable while the toggle crosses
  dbg_pkg::word_t addr_q;
  dbg_pkg::word_t wdata_q;
  logic           we_q;

  // Start toggle and its cpu_clk synchronizer, third flop for edge detect
  logic           str_tgl_q;
  logic           str_ff1_q;
  logic           str_ff2_q;
  logic           str_ff3_q;
  logic           start;

  // Ready toggle and its TCK synchronizer
  logic           rdy_tgl_q;
  logic           rdy_ff1_q;
  logic           rdy_ff2_q;
  logic           rdy_ff3_q;

  // SPR side
  dbg_pkg::word_t rdata_q;
  spr_state_t     state_q;
  spr_state_t     state_d;
  logic           xfer_done;
  logic           accept;

  ////////////////////////////////////////////////////////////////////////////
  // TCK domain
  ////////////////////////////////////////////////////////////////////////////

  // Strobe only counts while idle
  assign accept = strobe_i && rdy_o;

  always_ff @(posedge tck_i) begin
    if (accept) begin
      addr_q <= addr_i;
      if (!rd_wrn_i) begin
        wdata_q <= data_i;
      end
    end
  end

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      we_q      <= 1'b0;
      str_tgl_q <= 1'b0;
      rdy_ff1_q <= 1'b0;
      rdy_ff2_q <= 1'b0;
      rdy_ff3_q <= 1'b0;
      rdy_o     <= 1'b1;
    end else begin
      rdy_ff1_q <= rdy_tgl_q;
      rdy_ff2_q <= rdy_ff1_q;
      rdy_ff3_q <= rdy_ff2_q;
      if (accept) begin
        we_q      <= !rd_wrn_i;
        str_tgl_q <= !str_tgl_q;
        rdy_o     <= 1'b0;
      end else if (rdy_ff2_q != rdy_ff3_q) begin
        // Return toggle has arrived, access complete
        rdy_o <= 1'b1;
      end
    end
  end

  // Quasi-static across the crossing, no sync needed
  assign cpu_addr_o = addr_q;
  assign cpu_data_o = wdata_q;
  assign cpu_we_o   = we_q;
  assign data_o     = rdata_q;

  ////////////////////////////////////////////////////////////////////////////
  // cpu_clk domain
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge cpu_clk_i or posedge rst_i) begin
    if (rst_i) begin
      str_ff1_q <= 1'b0;
      str_ff2_q <= 1'b0;
      str_ff3_q <= 1'b0;
      rdy_tgl_q <= 1'b0;
      state_q   <= st_idle;
    end else begin
      str_ff1_q <= str_tgl_q;
      str_ff2_q <= str_ff1_q;
      str_ff3_q <= str_ff2_q;
      state_q   <= state_d;
      if (xfer_done) begin
        rdy_tgl_q <= !rdy_tgl_q;
      end
    end
  end

  // One-cycle pulse per access request
  assign start = str_ff2_q ^ str_ff3_q;

  // Read data captured on ack
  always_ff @(posedge cpu_clk_i) begin
    if (xfer_done && !we_q) begin
      rdata_q <= cpu_data_i;
    end
  end

  // Ack together with the first stb is a single-cycle access, no xfer state
  always_comb begin
    state_d   = state_q;
    cpu_stb_o = 1'b0;
    xfer_done = 1'b0;
    case (state_q)
      st_idle: begin
        if (start) begin
          cpu_stb_o = 1'b1;
          if (cpu_ack_i) begin
            xfer_done = 1'b1;
          end else begin
            state_d = st_xfer;
          end
        end
      end
      st_xfer: begin
        // Hold stb until the target acks
        cpu_stb_o = 1'b1;
        if (cpu_ack_i) begin
          xfer_done = 1'b1;
          state_d   = st_idle;
        end
      end
      default: state_d = st_idle;
    endcase
  end

endmodule

// ==== dbg_crc32.sv ====
// Word-serial CRC-32 accumulator over burst data, one word folded per cycle
`timescale 1ns/1ps

module dbg_crc32 (
  input  logic           tck_i,
  input  logic           rst_i,
  input  logic           clear_i,
  input  logic           update_i,
  input  dbg_pkg::word_t data_i,
  output dbg_pkg::word_t crc_o
);

  dbg_pkg::word_t crc_q;

  // MSB-first fold of one data word, 32 bit steps unrolled in one cycle
  function automatic dbg_pkg::word_t crc_fold(input dbg_pkg::word_t crc,
                                              input dbg_pkg::word_t data);
    dbg_pkg::word_t c;
    logic           fb;
    c = crc;
    for (int i = dbg_pkg::word_w - 1; i >= 0; i--) begin
      fb = c[dbg_pkg::word_w-1] ^ data[i];
      c  = {c[dbg_pkg::word_w-2:0], 1'b0};
      if (fb) begin
        c = c ^ dbg_pkg::crc_poly;
      end
    end
    return c;
  endfunction

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      crc_q <= dbg_pkg::crc_init;
    end else if (clear_i) begin
      // New burst
      crc_q <= dbg_pkg::crc_init;
    end else if (update_i) begin
      crc_q <= crc_fold(crc_q, data_i);
    end
  end

  // No final inversion
  assign crc_o = crc_q;

endmodule

// ==== dbg_burst_ctrl.sv ====
// TCK-domain burst controller FSM sequencing commands, write intake, read pushes and completion
`timescale 1ns/1ps

module dbg_burst_ctrl (
  input  logic                             tck_i,
  input  logic                             rst_i,

  // Command FIFO
  input  logic                             cmd_empty_i,
  input  dbg_pkg::dbg_cmd_t                cmd_i,
  output logic                             cmd_pop_o,

  // Host write data
  input  logic                             wdata_valid_i,
  output logic                             wdata_ready_o,
  input  dbg_pkg::word_t                   wdata_i,

  // Bridge
  output logic                             br_strobe_o,
  output logic                             br_rd_wrn_o,
  output dbg_pkg::word_t                   br_addr_o,
  output dbg_pkg::word_t                   br_wdata_o,
  input  logic                             br_rdy_i,
  input  dbg_pkg::word_t                   br_rdata_i,

  // Read FIFO
  output logic                             rfifo_push_o,
  output dbg_pkg::word_t                   rfifo_data_o,
  input  logic [dbg_pkg::rdata_cnt_w-1:0]  rfifo_count_i,

  // CRC
  output logic                             crc_clear_o,
  output logic                             crc_update_o,
  output dbg_pkg::word_t                   crc_data_o,

  output logic                             done_o
);

  typedef enum logic [1:0] {
    st_idle,
    st_issue,
    st_wait
  } ctrl_state_t;

  ctrl_state_t    state_q;
  logic           write_q;
  dbg_pkg::word_t addr_q;
  dbg_pkg::len_t  remain_q;
  logic           done_q;

  logic           rfifo_space;
  logic           issue;
  logic           complete;

  // At most one access outstanding and its push lands before the next issue,
  // so the count alone covers words in flight
  assign rfifo_space = int'(rfifo_count_i) < dbg_pkg::rdata_fifo_depth;

  ////////////////////////////////////////////////////////////////////////////
  // Handshakes
  ////////////////////////////////////////////////////////////////////////////

  // Next command taken as soon as the previous burst is finished
  assign cmd_pop_o   = (state_q == st_idle) && !cmd_empty_i;
  assign crc_clear_o = cmd_pop_o;

  // Write word accepted only when it can go straight to the bridge
  assign wdata_ready_o = (state_q == st_issue) && write_q && br_rdy_i;

  assign issue    = (state_q == st_issue) && br_rdy_i &&
                    (write_q ? wdata_valid_i : rfifo_space);
  assign complete = (state_q == st_wait) && br_rdy_i;

  assign br_strobe_o = issue;
  assign br_rd_wrn_o = !write_q;
  assign br_addr_o   = addr_q;
  assign br_wdata_o  = wdata_i;

  // Read word returned on completion
  assign rfifo_push_o = complete && !write_q;
  assign rfifo_data_o = br_rdata_i;

  // Write words enter the CRC when issued, read words when returned
  assign crc_update_o = write_q ? issue : complete;
  assign crc_data_o   = write_q ? wdata_i : br_rdata_i;

  // Registered so crc_o already holds the last word at done_o
  assign done_o = done_q;

  ////////////////////////////////////////////////////////////////////////////
  // Sequencing
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge tck_i) begin
    if (cmd_pop_o) begin
      write_q <= cmd_i.write;
      addr_q  <= cmd_i.addr;
    end else if (complete) begin
      // Consecutive word addresses
      addr_q <= addr_q + 1'b1;
    end
  end

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      state_q  <= st_idle;
      remain_q <= '0;
      done_q   <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        st_idle: begin
          if (cmd_pop_o) begin
            remain_q <= cmd_i.len_m1;
            state_q  <= st_issue;
          end
        end
        st_issue: begin
          // Waits on bridge, write data or read FIFO room
          if (issue) begin
            state_q <= st_wait;
          end
        end
        st_wait: begin
          if (complete) begin
            if (remain_q == '0) begin
              done_q  <= 1'b1;
              state_q <= st_idle;
            end else begin
              remain_q <= remain_q - 1'b1;
              state_q  <= st_issue;
            end
          end
        end
        default: state_q <= st_idle;
      endcase
    end
  end

endmodule

// ==== dbg_cpu_top.sv ====
// Debug CPU-access top level with command and read FIFOs, burst controller, bridge and CRC
`timescale 1ns/1ps

module dbg_cpu_top (
  input  logic                 tck_i,
  input  logic                 cpu_clk_i,
  input  logic                 rst_i,

  // Host command
  input  logic                 cmd_valid_i,
  output logic                 cmd_ready_o,
  input  logic                 cmd_write_i,
  input  dbg_pkg::word_t       cmd_addr_i,
  input  dbg_pkg::len_t        cmd_len_m1_i,

  // Host write data
  input  logic                 wdata_valid_i,
  output logic                 wdata_ready_o,
  input  dbg_pkg::word_t       wdata_i,

  // Host read data
  output logic                 rdata_valid_o,
  input  logic                 rdata_ready_i,
  output dbg_pkg::word_t       rdata_o,

  // Burst completion
  output logic                 done_o,
  output dbg_pkg::word_t       crc_o,

  // SPR bus
  output dbg_pkg::word_t       cpu_addr_o,
  output dbg_pkg::word_t       cpu_data_o,
  output logic                 cpu_we_o,
  output logic                 cpu_stb_o,
  input  dbg_pkg::word_t       cpu_data_i,
  input  logic                 cpu_ack_i
);

  // Command path
  dbg_pkg::dbg_cmd_t              cmd_in;
  dbg_pkg::dbg_cmd_t              cmd_head;
  logic                           cmd_full;
  logic                           cmd_empty;
  logic                           cmd_pop;

  // Read data path
  logic                           rf_push;
  dbg_pkg::word_t                 rf_data;
  logic                           rf_empty;
  logic [dbg_pkg::rdata_cnt_w-1:0] rf_count;

  // Controller to bridge and CRC
  logic                           br_strobe;
  logic                           br_rd_wrn;
  dbg_pkg::word_t                 br_addr;
  dbg_pkg::word_t                 br_wdata;
  logic                           br_rdy;
  dbg_pkg::word_t                 br_rdata;
  logic                           crc_clear;
  logic                           crc_update;
  dbg_pkg::word_t                 crc_data;

  assign cmd_in.write  = cmd_write_i;
  assign cmd_in.addr   = cmd_addr_i;
  assign cmd_in.len_m1 = cmd_len_m1_i;

  assign cmd_ready_o   = !cmd_full;
  assign rdata_valid_o = !rf_empty;

  dbg_fifo #(
    .payload_t (dbg_pkg::dbg_cmd_t),
    .depth     (dbg_pkg::cmd_fifo_depth)
  ) cmd_fifo_i (
    .tck_i   (tck_i),
    .rst_i   (rst_i),
    .push_i  (cmd_valid_i && cmd_ready_o),
    .data_i  (cmd_in),
    .pop_i   (cmd_pop),
    .data_o  (cmd_head),
    .full_o  (cmd_full),
    .empty_o (cmd_empty),
    .count_o ()
  );

  // Room is checked by the controller through the count
  dbg_fifo #(
    .payload_t (dbg_pkg::word_t),
    .depth     (dbg_pkg::rdata_fifo_depth)
  ) rdata_fifo_i (
    .tck_i   (tck_i),
    .rst_i   (rst_i),
    .push_i  (rf_push),
    .data_i  (rf_data),
    .pop_i   (rdata_valid_o && rdata_ready_i),
    .data_o  (rdata_o),
    .full_o  (),
    .empty_o (rf_empty),
    .count_o (rf_count)
  );

  dbg_burst_ctrl dbg_burst_ctrl_i (
    .tck_i         (tck_i),
    .rst_i         (rst_i),
    .cmd_empty_i   (cmd_empty),
    .cmd_i         (cmd_head),
    .cmd_pop_o     (cmd_pop),
    .wdata_valid_i (wdata_valid_i),
    .wdata_ready_o (wdata_ready_o),
    .wdata_i       (wdata_i),
    .br_strobe_o   (br_strobe),
    .br_rd_wrn_o   (br_rd_wrn),
    .br_addr_o     (br_addr),
    .br_wdata_o    (br_wdata),
    .br_rdy_i      (br_rdy),
    .br_rdata_i    (br_rdata),
    .rfifo_push_o  (rf_push),
    .rfifo_data_o  (rf_data),
    .rfifo_count_i (rf_count),
    .crc_clear_o   (crc_clear),
    .crc_update_o  (crc_update),
    .crc_data_o    (crc_data),
    .done_o        (done_o)
  );

  dbg_cpu_bridge dbg_cpu_bridge_i (
    .tck_i      (tck_i),
    .rst_i      (rst_i),
    .strobe_i   (br_strobe),
    .rd_wrn_i   (br_rd_wrn),
    .addr_i     (br_addr),
    .data_i     (br_wdata),
    .data_o     (br_rdata),
    .rdy_o      (br_rdy),
    .cpu_clk_i  (cpu_clk_i),
    .cpu_addr_o (cpu_addr_o),
    .cpu_data_i (cpu_data_i),
    .cpu_data_o (cpu_data_o),
    .cpu_stb_o  (cpu_stb_o),
    .cpu_we_o   (cpu_we_o),
    .cpu_ack_i  (cpu_ack_i)
  );

  dbg_crc32 dbg_crc32_i (
    .tck_i    (tck_i),
    .rst_i    (rst_i),
    .clear_i  (crc_clear),
    .update_i (crc_update),
    .data_i   (crc_data),
    .crc_o    (crc_o)
  );

endmodule

// ==== tb_clk_gen.sv ====
// Free-running testbench clock source with a period parameter in ns
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter real period_ns = 100.0
) (
  output logic clk_o
);

  // Starts low, first rising edge after half a period
  initial begin
    clk_o = 1'b0;
    forever begin
      #(period_ns / 2.0);
      clk_o = ~clk_o;
    end
  end

endmodule

// ==== tb_dbg_cpu_top.sv ====
// Testbench for the debug CPU unit with SPR target model, reference model, checks and timeout
`timescale 1ns/1ps

module tb_dbg_cpu_top;

  localparam int num_single     = 4;
  localparam int num_rand_cmds  = 40;
  localparam int num_readback   = 4;
  localparam int num_total_cmds = 2 * num_single + num_rand_cmds + num_readback;
  // Worst case of 16 words per burst and 40 tck cycles per word
  localparam int timeout_cycles = num_total_cmds * 16 * 40 + 1000;

  logic                 tck_i;
  logic                 cpu_clk_i;
  logic                 rst_i;

  // DUT inputs start idle
  logic                 cmd_valid_i   = 1'b0;
  logic                 cmd_write_i   = 1'b0;
  dbg_pkg::word_t       cmd_addr_i    = '0;
  dbg_pkg::len_t        cmd_len_m1_i  = '0;
  logic                 wdata_valid_i = 1'b0;
  dbg_pkg::word_t       wdata_i       = '0;
  logic                 rdata_ready_i = 1'b0;
  dbg_pkg::word_t       cpu_data_i    = '0;
  logic                 cpu_ack_i     = 1'b0;

  logic                 cmd_ready_o;
  logic                 wdata_ready_o;
  logic                 rdata_valid_o;
  dbg_pkg::word_t       rdata_o;
  logic                 done_o;
  dbg_pkg::word_t       crc_o;
  dbg_pkg::word_t       cpu_addr_o;
  dbg_pkg::word_t       cpu_data_o;
  logic                 cpu_we_o;
  logic                 cpu_stb_o;

  // Reference model and SPR target memories indexed by addr[7:0]
  dbg_pkg::word_t       shadow_mem [256];
  dbg_pkg::word_t       spr_mem    [256];

  // Pending host traffic and expected responses
  dbg_pkg::dbg_cmd_t    cmd_q [$];
  dbg_pkg::dbg_cmd_t    burst_q [$];
  dbg_pkg::word_t       crc_q [$];
  dbg_pkg::word_t       wdata_q [$];
  dbg_pkg::word_t       rdata_q [$];

  // Accesses seen on the SPR bus during the current burst
  dbg_pkg::word_t       log_addr_q [$];
  logic                 log_we_q [$];

  logic                 spr_busy = 1'b0;
  int                   spr_wait = 0;
  int                   sink_hold = 0;
  int                   error_count = 0;
  int                   test_count = 0;
  int                   test_fail_count = 0;
  int                   burst_total = 0;
  int                   done_count = 0;
  int                   cycle_count = 0;
  string                test_name = "";

  tb_clk_gen #(.period_ns(100.0)) cpu_clk_gen_i (.clk_o(cpu_clk_i));
  tb_clk_gen #(.period_ns(130.0)) tck_gen_i (.clk_o(tck_i));

  dbg_cpu_top dbg_cpu_top_i (
    .tck_i         (tck_i),
    .cpu_clk_i     (cpu_clk_i),
    .rst_i         (rst_i),
    .cmd_valid_i   (cmd_valid_i),
    .cmd_ready_o   (cmd_ready_o),
    .cmd_write_i   (cmd_write_i),
    .cmd_addr_i    (cmd_addr_i),
    .cmd_len_m1_i  (cmd_len_m1_i),
    .wdata_valid_i (wdata_valid_i),
    .wdata_ready_o (wdata_ready_o),
    .wdata_i       (wdata_i),
    .rdata_valid_o (rdata_valid_o),
    .rdata_ready_i (rdata_ready_i),
    .rdata_o       (rdata_o),
    .done_o        (done_o),
    .crc_o         (crc_o),
    .cpu_addr_o    (cpu_addr_o),
    .cpu_data_o    (cpu_data_o),
    .cpu_we_o      (cpu_we_o),
    .cpu_stb_o     (cpu_stb_o),
    .cpu_data_i    (cpu_data_i),
    .cpu_ack_i     (cpu_ack_i)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Reference model helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (expected !== actual) begin
      $display("FAIL %s %s: expected %h, actual %h", test_name, name, expected, actual);
      error_count++;
    end
  endtask

  // CRC-32 over one word MSB first without final inversion
  function automatic dbg_pkg::word_t crc_next(input dbg_pkg::word_t crc,
                                              input dbg_pkg::word_t data);
    dbg_pkg::word_t r;
    r = crc;
    for (int b = 31; b >= 0; b--) begin
      if (r[31] != data[b]) begin
        r = (r << 1) ^ dbg_pkg::crc_poly;
      end else begin
        r = r << 1;
      end
    end
    return r;
  endfunction

  // Distinct start value per memory word
  function automatic dbg_pkg::word_t fill_word(input int i);
    return {8'(i), 8'(~i), 8'(i ^ 8'h5a), 8'h3c};
  endfunction

  // Low byte kept small so bursts overlap and reads see earlier writes
  function automatic dbg_pkg::word_t rand_addr();
    dbg_pkg::word_t a;
    a      = $urandom;
    a[7:0] = 8'($urandom % 48);
    return a;
  endfunction

  // Builds one command with its data, expected reads and expected CRC
  task automatic queue_command(input logic write, input dbg_pkg::word_t addr,
                               input dbg_pkg::len_t len_m1);
    dbg_pkg::dbg_cmd_t cmd;
    dbg_pkg::word_t    crc;
    dbg_pkg::word_t    w;
    logic [7:0]        idx;
    cmd.write  = write;
    cmd.addr   = addr;
    cmd.len_m1 = len_m1;
    crc        = dbg_pkg::crc_init;
    for (int i = 0; i <= int'(len_m1); i++) begin
      idx = addr[7:0] + 8'(i);
      if (write) begin
        w = $urandom;
        shadow_mem[idx] = w;
        wdata_q.push_back(w);
      end else begin
        w = shadow_mem[idx];
        rdata_q.push_back(w);
      end
      crc = crc_next(crc, w);
    end
    cmd_q.push_back(cmd);
    burst_q.push_back(cmd);
    crc_q.push_back(crc);
    burst_total++;
  endtask

  task automatic wait_bursts();
    while (done_count < burst_total || rdata_q.size() != 0) begin
      @(negedge tck_i);
    end
  endtask

  task automatic end_test(input string name, input int errors_at_start);
    test_count++;
    if (error_count == errors_at_start) begin
      $display("test %s: ok", name);
    end else begin
      test_fail_count++;
      $display("test %s: %0d errors", name, error_count - errors_at_start);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Host side drivers and monitors on the falling tck edge
  ////////////////////////////////////////////////////////////////////////////

  // Command port offers the head of the queue until taken
  always @(negedge tck_i) begin
    if (rst_i || cmd_q.size() == 0) begin
      cmd_valid_i = 1'b0;
    end else begin
      cmd_valid_i  = 1'b1;
      cmd_write_i  = cmd_q[0].write;
      cmd_addr_i   = cmd_q[0].addr;
      cmd_len_m1_i = cmd_q[0].len_m1;
      if (cmd_ready_o) begin
        void'(cmd_q.pop_front());
      end
    end
  end

  // Write data with random gaps
  always @(negedge tck_i) begin
    if (rst_i || wdata_q.size() == 0) begin
      wdata_valid_i = 1'b0;
    end else begin
      wdata_valid_i = ($urandom % 4) != 0;
      wdata_i       = wdata_q[0];
      if (wdata_valid_i && wdata_ready_o) begin
        void'(wdata_q.pop_front());
      end
    end
  end

  // Read sink with random ready plus long stalls that fill the read FIFO
  always @(negedge tck_i) begin
    if (rst_i) begin
      rdata_ready_i = 1'b0;
    end else if (sink_hold > 0) begin
      rdata_ready_i = 1'b0;
      sink_hold--;
    end else begin
      rdata_ready_i = ($urandom % 3) != 0;
      if (($urandom % 32) == 0) begin
        sink_hold = $urandom % 64;
      end
      // Word leaves the FIFO on the next rising edge
      if (rdata_ready_i && rdata_valid_o) begin
        if (rdata_q.size() == 0) begin
          $display("ERROR: read word %h returned with none expected", rdata_o);
          error_count++;
        end else begin
          check("read_data", rdata_q.pop_front(), rdata_o);
        end
      end
    end
  end

  // Burst completion, CRC and SPR access sequence
  always @(negedge tck_i) begin : done_monitor
    dbg_pkg::dbg_cmd_t done_cmd;
    if (!rst_i && done_o) begin
      if (burst_q.size() == 0) begin
        $display("ERROR: done_o pulsed with no burst outstanding");
        error_count++;
      end else begin
        done_cmd = burst_q.pop_front();
        check("burst_crc", crc_q.pop_front(), crc_o);
        check("burst_len", 32'(done_cmd.len_m1) + 1, log_addr_q.size());
        for (int i = 0; i < log_addr_q.size(); i++) begin
          check("burst_addr", done_cmd.addr + dbg_pkg::word_t'(i), log_addr_q[i]);
          check("burst_dir", 32'(done_cmd.write), 32'(log_we_q[i]));
        end
      end
      log_addr_q.delete();
      log_we_q.delete();
      done_count++;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // SPR target model that acks after 0 to 3 cpu_clk cycles
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge cpu_clk_i) begin
    if (rst_i) begin
      cpu_ack_i = 1'b0;
      spr_busy  = 1'b0;
    end else if (cpu_ack_i) begin
      // Access completed on the last rising edge
      cpu_ack_i = 1'b0;
    end else if (cpu_stb_o) begin
      if (!spr_busy) begin
        spr_busy = 1'b1;
        spr_wait = $urandom % 4;
        log_addr_q.push_back(cpu_addr_o);
        log_we_q.push_back(cpu_we_o);
      end
      if (spr_wait == 0) begin
        cpu_ack_i = 1'b1;
        spr_busy  = 1'b0;
        if (cpu_we_o) begin
          spr_mem[cpu_addr_o[7:0]] = cpu_data_o;
        end else begin
          cpu_data_i = spr_mem[cpu_addr_o[7:0]];
        end
      end else begin
        spr_wait--;
      end
    end
  end

  // Hang guard
  initial begin : hang_guard
    while (cycle_count < timeout_cycles) begin
      @(posedge tck_i);
      cycle_count++;
    end
    $display("ERROR: run hung, not finished after %0d tck cycles", cycle_count);
    $display("Some tests failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int             errs;
    dbg_pkg::word_t base;
    rst_i = 1'b1;
    void'($urandom(32'h5b7));
    for (int i = 0; i < 256; i++) begin
      shadow_mem[i] = fill_word(i);
      spr_mem[i]    = fill_word(i);
    end
    repeat (4) @(negedge cpu_clk_i);
    rst_i = 1'b0;

    // Idle outputs before any command
    test_name = "reset_state";
    errs = error_count;
    @(negedge tck_i);
    check("reset_cpu_stb", 32'd0, 32'(cpu_stb_o));
    check("reset_done", 32'd0, 32'(done_o));
    check("reset_rdata_valid", 32'd0, 32'(rdata_valid_o));
    check("reset_wdata_ready", 32'd0, 32'(wdata_ready_o));
    check("reset_cmd_ready", 32'd1, 32'(cmd_ready_o));
    end_test(test_name, errs);

    // Single-word writes followed by reads of the same words
    test_name = "single_word";
    errs = error_count;
    base = rand_addr();
    @(posedge tck_i);
    for (int i = 0; i < num_single; i++) begin
      queue_command(1'b1, base + dbg_pkg::word_t'(i), '0);
    end
    for (int i = 0; i < num_single; i++) begin
      queue_command(1'b0, base + dbg_pkg::word_t'(i), '0);
    end
    wait_bursts();
    end_test(test_name, errs);

    // Mixed bursts with several queued behind the running one
    test_name = "random_bursts";
    errs = error_count;
    @(posedge tck_i);
    for (int n = 0; n < num_rand_cmds; n++) begin
      queue_command(1'($urandom % 2), rand_addr(), dbg_pkg::len_t'($urandom % 16));
    end
    wait_bursts();
    end_test(test_name, errs);

    // Full sweep of the touched region against the shadow memory
    test_name = "readback";
    errs = error_count;
    @(posedge tck_i);
    for (int n = 0; n < num_readback; n++) begin
      queue_command(1'b0, dbg_pkg::word_t'(n * 16), 4'hf);
    end
    wait_bursts();
    end_test(test_name, errs);

    $display("Summary: %0d tests, %0d with errors, %0d failed checks",
             test_count, test_fail_count, error_count);
    if (error_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
dbg_pkg.sv
dbg_fifo.sv
dbg_cpu_bridge.sv
dbg_crc32.sv
dbg_burst_ctrl.sv
dbg_cpu_top.sv
tb_clk_gen.sv
tb_dbg_cpu_top.sv

// ==== Makefile ====
TOP = tb_dbg_cpu_top

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -Wno-fatal -f sources.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee sim.log
	grep -q "^All tests passed$$" sim.log

lint:
	verilator --lint-only --timing -Wall -f sources.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
